// File: decodeStage.f
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/decodeControl.sv
hdl/regFileBypass.sv
hdl/immExtend.sv
hdl/decodeStage.sv
tests/decodeStage_chk.sv
tests/decodeStage_tb.sv

// File: Makefile
# Verilator build and run of the decode stage testbench
# any variable can be overridden, e.g. make BUILD_DIR=build LOG=run.log

VERILATOR ?= verilator
TOP       ?= decodeStage_tb
DUT_TOP   ?= decodeStage
FILELIST  ?= decodeStage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
# keep running past assertion errors so the testbench prints its summary
SIMFLAGS  ?= +verilator+error+limit+100000
PASS_MSG  ?= All tests passed!

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(SIM_BIN) $(SIMFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation FAILED, see $(LOG)"; exit 1)
	@echo "simulation passed"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(DUT_TOP) \
		hdl/isaPkg.sv hdl/ctrlPkg.sv hdl/decodeControl.sv \
		hdl/regFileBypass.sv hdl/immExtend.sv hdl/decodeStage.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/decodeStage_tb.sv
`timescale 1ns/10ps

module decodeStage_tb;

	import isaPkg::*;
	import ctrlPkg::*;

	localparam int clkPeriod = 20;
	localparam int numDirected = 128;
	localparam int numRandom = 400;
	// one cycle per instruction plus reset and flush cycles and some slack
	localparam int timeoutNs = (numDirected + numRandom + 10) * clkPeriod + 1000;
	// must agree with the register file setting inside the DUT
	localparam bit bypassOn = 1'b1;

	logic clk;
	logic arstN;
	logic inValid;
	word_t instr;
	wbBus_t wb;
	logic outValid;
	idEx_t idEx;
	logic err;
	logic dump;

	int seed = 32'h27f7;
	int errors = 0;
	// reference model state
	word_t shadow [8];
	idEx_t expRec;
	logic expValid;
	logic expErr;
	logic expDump;

	decodeStage uut (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (inValid),
		.instr    (instr),
		.wb       (wb),
		.outValid (outValid),
		.idEx     (idEx),
		.err      (err),
		.dump     (dump)
	);

	// handshake and control checks live inside the DUT scope
	bind decodeStage decodeStage_chk chk (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (inValid),
		.outValid (outValid),
		.err      (err),
		.dump     (dump),
		.idEx     (idEx)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial begin
		#(timeoutNs);
		$display("watchdog expired, the DUT run did not complete in time");
		$display("Test failures found");
		$finish;
	end

	// control bundle straight from the per-signal opcode rules
	function automatic ctrl_t decodeCtrl(input word_t ins);
		opcode_t op;
		logic [1:0] fn;
		ctrl_t c;
		op = opcode_t'(ins[15:11]);
		fn = ins[1:0];
		c = '0;
		if (!(op inside {HALT, NOP, J, JR, JAL, JALR, ADDI, SUBI, XORI, ANDNI,
				BEQZ, BNEZ, ST, LD, SLBI, STU, LBI, ALUR})) begin
			c.illegal = 1'b1;
			return c;
		end
		c.regWrite = op inside {ADDI, SUBI, XORI, ANDNI, LD, STU, LBI, SLBI, JAL, JALR, ALUR};
		c.memEn = op inside {ST, LD, STU};
		c.memWrite = op inside {ST, STU};
		c.memToReg = (op == LD);
		c.aluSrcImm = op inside {ADDI, SUBI, XORI, ANDNI, ST, LD, STU, LBI, SLBI};
		c.branch = op inside {BEQZ, BNEZ};
		c.jump = op inside {J, JR, JAL, JALR};
		c.jumpReg = op inside {JR, JALR};
		c.link = op inside {JAL, JALR};
		c.invA = (op inside {SUBI, LBI}) || (op == ALUR && fn == 2'd1);
		c.invB = (op == ANDNI) || (op == ALUR && fn == 2'd3);
		c.cIn = (op == SUBI) || (op == ALUR && fn == 2'd1);
		c.dump = (op == HALT);
		// codes 1 to 3 select xor, and or byte merge
		if ((op inside {XORI, BNEZ}) || (op == ALUR && fn == 2'd2)) begin
			c.aluOp = 2'd1;
		end else if (op == ANDNI || (op == ALUR && fn == 2'd3)) begin
			c.aluOp = 2'd2;
		end else if (op inside {LBI, SLBI}) begin
			c.aluOp = 2'd3;
		end
		return c;
	endfunction

	// mask the field and subtract 2**n when its top bit is set
	function automatic word_t extendImm(input word_t ins);
		opcode_t op;
		word_t v;
		op = opcode_t'(ins[15:11]);
		v = '0;
		if (op inside {ADDI, SUBI, ST, LD, STU}) begin
			v = ins & 16'h001f;
			if (ins[4]) v = v - 16'h0020;
		end else if (op inside {XORI, ANDNI}) begin
			v = ins & 16'h001f;
		end else if (op inside {LBI, BEQZ, BNEZ, JR, JALR}) begin
			v = ins & 16'h00ff;
			if (ins[7]) v = v - 16'h0100;
		end else if (op == SLBI) begin
			v = ins & 16'h00ff;
		end else if (op inside {J, JAL}) begin
			v = ins & 16'h07ff;
			if (ins[10]) v = v - 16'h0800;
		end
		return v;
	endfunction

	function automatic regIdx_t pickDst(input word_t ins);
		opcode_t op;
		op = opcode_t'(ins[15:11]);
		if (op == ALUR) return ins[4:2];
		if (op inside {LBI, SLBI, STU}) return ins[10:8];
		if (op inside {JAL, JALR}) return 3'd7;
		return ins[7:5];
	endfunction

	// shadow read where a same-cycle write wins
	function automatic word_t readShadow(input regIdx_t sel, input wbBus_t w);
		if (bypassOn && w.en && w.sel == sel) return w.data;
		return shadow[sel];
	endfunction

	// writeback half the time with a quarter of those aimed at rs
	function automatic wbBus_t randomWb(input word_t ins);
		logic [31:0] r;
		wbBus_t w;
		r = $random(seed);
		w.en = r[0];
		w.sel = (r[2:1] == 2'b00) ? ins[10:8] : r[5:3];
		w.data = r[31:16];
		return w;
	endfunction

	task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
		assert (act === exp) else begin
			$display("** Error at %0t: %s expected 0x%h, actual 0x%h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic compareOutputs();
		check("outValid", 16'(expValid), 16'(outValid));
		check("err", 16'(expErr), 16'(err));
		check("dump", 16'(expDump), 16'(dump));
		check("idEx.ctrl", expRec.ctrl, idEx.ctrl);
		check("idEx.a", expRec.a, idEx.a);
		check("idEx.b", expRec.b, idEx.b);
		check("idEx.imm", expRec.imm, idEx.imm);
		check("idEx.dst", 16'(expRec.dst), 16'(idEx.dst));
	endtask

	// check the last cycle and drive the next one before the clock
	task automatic cycle(input logic v, input word_t ins, input wbBus_t w);
		ctrl_t c;
		compareOutputs();
		c = decodeCtrl(ins);
		inValid = v;
		instr = ins;
		wb = w;
		expValid = v;
		expErr = v && c.illegal;
		expDump = v && c.dump;
		// record holds without a strobe
		if (v) begin
			expRec.ctrl = c;
			expRec.a = readShadow(ins[10:8], w);
			expRec.b = readShadow(ins[7:5], w);
			expRec.imm = extendImm(ins);
			expRec.dst = pickDst(ins);
		end
		// write lands on the coming rising edge
		if (w.en) shadow[w.sel] = w.data;
		@(negedge clk);
	endtask

	initial begin
		logic [31:0] r;
		word_t ins;
		arstN = 1'b0;
		inValid = 1'b0;
		instr = '0;
		wb = '0;
		for (int i = 0; i < 8; i++) begin
			shadow[i] = '0;
		end
		expRec = '0;
		expValid = 1'b0;
		expErr = 1'b0;
		expDump = 1'b0;
		repeat (2) @(negedge clk);
		arstN = 1'b1;
		// every opcode with each funct and negative fields on odd funct
		for (int k = 0; k < numDirected; k++) begin
			r = $random(seed);
			ins = r[15:0];
			ins[15:11] = 5'(k / 4);
			ins[1:0] = 2'(k % 4);
			ins[10] = k[0];
			ins[7] = k[0];
			ins[4] = k[0];
			cycle(1'b1, ins, randomWb(ins));
		end
		// random words with strobe gaps about one cycle in four
		for (int k = 0; k < numRandom; k++) begin
			r = $random(seed);
			ins = r[15:0];
			cycle(r[17:16] != 2'b00, ins, randomWb(ins));
		end
		// flush the last record and watch it hold
		cycle(1'b0, '0, '0);
		cycle(1'b0, '0, '0);
		compareOutputs();
		$display("scoreboard errors: %0d, assertion failures: %0d", errors, uut.chk.failCount);
		if (errors == 0 && uut.chk.failCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: tests/decodeStage_chk.sv
`timescale 1ns/10ps

module decodeStage_chk (
	input logic           clk,
	input logic           arstN,
	input logic           inValid,
	input logic           outValid,
	input logic           err,
	input logic           dump,
	input ctrlPkg::idEx_t idEx
);

	import ctrlPkg::*;

	// failed assertions so far, the testbench reads it at the end
	int failCount = 0;

	ctrl_t c;
	logic anyEnable;

	assign c = idEx.ctrl;
	// everything that makes a later stage act
	assign anyEnable = c.regWrite | c.memEn | c.memWrite | c.memToReg | c.aluSrcImm
		| c.branch | c.jump | c.jumpReg | c.link | c.dump;

	// one cycle of latency, back-to-back included
	validFollows: assert property (@(posedge clk) disable iff (!arstN)
		inValid |=> outValid)
	else begin
		$error("outValid missing one cycle after inValid");
		failCount++;
	end

	noSpuriousValid: assert property (@(posedge clk) disable iff (!arstN)
		!inValid |=> !outValid)
	else begin
		$error("outValid set without a preceding inValid");
		failCount++;
	end

	// flags already clear on the first edge after reset
	resetClears: assert property (@(posedge clk)
		!arstN |=> (!outValid && !err && !dump))
	else begin
		$error("outValid, err or dump set right after reset");
		failCount++;
	end

	// a store never loads
	memExclusive: assert property (@(posedge clk) disable iff (!arstN)
		!(c.memWrite && c.memToReg))
	else begin
		$error("memWrite and memToReg both set in idEx");
		failCount++;
	end

	illegalQuiet: assert property (@(posedge clk) disable iff (!arstN)
		err |-> !anyEnable)
	else begin
		$error("err raised with an enable still set in idEx.ctrl");
		failCount++;
	end

endmodule

// File: hdl/decodeStage.sv
`timescale 1ns/10ps

module decodeStage (
	input  logic            clk,
	input  logic            arstN,
	input  logic            inValid,
	input  isaPkg::word_t   instr,
	input  ctrlPkg::wbBus_t wb,
	output logic            outValid,
	output ctrlPkg::idEx_t  idEx,
	output logic            err,
	output logic            dump
);

	import isaPkg::*;
	import ctrlPkg::*;

	// register file configuration handed down
	localparam int rfDataWidth = $bits(word_t);
	localparam bit rfBypass = 1'b1;

	opcode_t opcode;
	funct_t funct;
	ctrl_t ctrl;
	immKind_t immKind;
	dstSel_t dstSel;
	word_t rdDataA;
	word_t rdDataB;
	word_t imm;
	regIdx_t dst;

	assign opcode = opcode_t'(instr[opMsb:opLsb]);
	assign funct = instr[functMsb:functLsb];

	decodeControl control (
		.opcode  (opcode),
		.funct   (funct),
		.ctrl    (ctrl),
		.immKind (immKind),
		.dstSel  (dstSel)
	);

	// rs on port A, rt on port B
	regFileBypass #(
		.dataWidth    (rfDataWidth),
		.bypassEnable (rfBypass)
	) regFile (
		.clk     (clk),
		.arstN   (arstN),
		.rdSelA  (instr[rsMsb:rsLsb]),
		.rdSelB  (instr[rtMsb:rtLsb]),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.wr      (wb)
	);

	immExtend immGen (
		.field (instr[immFieldW-1:0]),
		.kind  (immKind),
		.imm   (imm)
	);

	// destination register index
	always_comb begin
		case (dstSel)
			rdR: dst = instr[rdRMsb:rdRLsb];
			rs: dst = instr[rsMsb:rsLsb];
			link7: dst = linkReg;
			default: dst = instr[rdIMsb:rdILsb];
		endcase
	end

	// ID/EX record, loaded only on a strobe
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
			err <= 1'b0;
			dump <= 1'b0;
			idEx <= '0;
		end else begin
			outValid <= inValid;
			// flags pulse together with outValid
			err <= inValid && ctrl.illegal;
			dump <= inValid && ctrl.dump;
			if (inValid) begin
				idEx <= '{ctrl: ctrl, a: rdDataA, b: rdDataB, imm: imm, dst: dst};
			end
		end
	end

endmodule

// File: hdl/immExtend.sv
`timescale 1ns/10ps

module immExtend (
	input  logic [isaPkg::immFieldW-1:0] field,
	input  isaPkg::immKind_t              kind,
	output isaPkg::word_t                 imm
);

	import isaPkg::*;

	// one mux instead of separate extenders per width
	always_comb begin
		case (kind)
			sext5: begin
				imm = {{11{field[4]}}, field[4:0]};
			end
			zext5: begin
				imm = {11'd0, field[4:0]};
			end
			sext8: begin
				imm = {{8{field[7]}}, field[7:0]};
			end
			zext8: begin
				imm = {8'd0, field[7:0]};
			end
			sext11: begin
				// J-format displacement, whole field
				imm = {{5{field[10]}}, field[10:0]};
			end
			default: begin
				// no immediate in this format
				imm = '0;
			end
		endcase
	end

endmodule

// File: hdl/regFileBypass.sv
`timescale 1ns/10ps

module regFileBypass #(
	parameter int dataWidth = 16,
	parameter bit bypassEnable = 1'b1
) (
	input  logic                   clk,
	input  logic                   arstN,
	input  isaPkg::regIdx_t        rdSelA,
	input  isaPkg::regIdx_t        rdSelB,
	output logic [dataWidth-1:0]   rdDataA,
	output logic [dataWidth-1:0]   rdDataB,
	input  ctrlPkg::wbBus_t        wr
);

	import isaPkg::*;

	// one entry per encodable register index
	localparam int numRegs = 2 ** $bits(regIdx_t);

	logic [dataWidth-1:0] regs [numRegs];

	// write on the rising edge, whole array clears on reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.en) begin
			regs[wr.sel] <= wr.data;
		end
	end

	// same-cycle write forwarded into the read
	function automatic logic [dataWidth-1:0] readPort(input regIdx_t sel);
		logic hit;
		hit = bypassEnable && wr.en && (wr.sel == sel);
		return hit ? wr.data : regs[sel];
	endfunction

	// compare made separately for each port
	always_comb begin
		rdDataA = readPort(rdSelA);
	end

	always_comb begin
		rdDataB = readPort(rdSelB);
	end

endmodule

// File: hdl/decodeControl.sv
`timescale 1ns/10ps

module decodeControl (
	input  isaPkg::opcode_t  opcode,
	input  isaPkg::funct_t   funct,
	output ctrlPkg::ctrl_t   ctrl,
	output isaPkg::immKind_t immKind,
	output ctrlPkg::dstSel_t dstSel
);

	import isaPkg::*;
	import ctrlPkg::*;

	always_comb begin
		// defaults are no enables, add and the I-format destination
		ctrl = '0;
		ctrl.aluOp = aluAdd;
		immKind = none;
		dstSel = rdI;

		case (opcode)
			HALT: begin
				ctrl.dump = 1'b1;
			end
			NOP: begin
				// bubble with defaults only
			end
			ADDI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				immKind = sext5;
			end
			SUBI: begin
				// imm - rs as imm + ~rs + 1
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.invA = 1'b1;
				ctrl.cIn = 1'b1;
				immKind = sext5;
			end
			XORI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = aluXor;
				immKind = zext5;
			end
			ANDNI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.invB = 1'b1;
				ctrl.aluOp = aluAnd;
				immKind = zext5;
			end
			ST: begin
				// address is rs + imm and data comes from rt
				ctrl.memEn = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				immKind = sext5;
			end
			LD: begin
				ctrl.regWrite = 1'b1;
				ctrl.memEn = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				immKind = sext5;
			end
			STU: begin
				// store and write the address back into rs
				ctrl.regWrite = 1'b1;
				ctrl.memEn = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				immKind = sext5;
				dstSel = rs;
			end
			LBI: begin
				// invA masks out rs so only the immediate remains
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.invA = 1'b1;
				ctrl.aluOp = aluByte;
				immKind = sext8;
				dstSel = rs;
			end
			SLBI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = aluByte;
				immKind = zext8;
				dstSel = rs;
			end
			BEQZ, BNEZ: begin
				ctrl.branch = 1'b1;
				ctrl.aluOp = (opcode == BNEZ) ? aluXor : aluAdd;
				immKind = sext8;
			end
			J: begin
				ctrl.jump = 1'b1;
				immKind = sext11;
			end
			JAL: begin
				ctrl.jump = 1'b1;
				ctrl.link = 1'b1;
				ctrl.regWrite = 1'b1;
				immKind = sext11;
				dstSel = link7;
			end
			JR: begin
				// target is rs + imm
				ctrl.jump = 1'b1;
				ctrl.jumpReg = 1'b1;
				immKind = sext8;
			end
			JALR: begin
				ctrl.jump = 1'b1;
				ctrl.jumpReg = 1'b1;
				ctrl.link = 1'b1;
				ctrl.regWrite = 1'b1;
				immKind = sext8;
				dstSel = link7;
			end
			ALUR: begin
				ctrl.regWrite = 1'b1;
				dstSel = rdR;
				case (funct)
					fnAdd: ctrl.aluOp = aluAdd;
					fnSub: begin
						// rt - rs
						ctrl.aluOp = aluAdd;
						ctrl.invA = 1'b1;
						ctrl.cIn = 1'b1;
					end
					fnXor: ctrl.aluOp = aluXor;
					fnAndn: begin
						ctrl.aluOp = aluAnd;
						ctrl.invB = 1'b1;
					end
				endcase
			end
			default: begin
				// unknown code leaves every enable clear
				ctrl.illegal = 1'b1;
			end
		endcase
	end

endmodule

// File: hdl/ctrlPkg.sv
package ctrlPkg;

	// which field of the instruction names the register to write
	typedef enum logic [1:0] {
		rdR,
		rdI,
		rs,
		link7
	} dstSel_t;

	// execute-stage operation select
	typedef logic [1:0] aluOp_t;

	localparam aluOp_t aluAdd = 2'b00;
	localparam aluOp_t aluXor = 2'b01;
	localparam aluOp_t aluAnd = 2'b10;
	// byte merge: (a << 8) | b, invA drops the a term
	localparam aluOp_t aluByte = 2'b11;

	// control bundle handed to execute, memory and writeback
	typedef struct packed {
		logic regWrite;
		logic memEn;
		logic memWrite;
		logic memToReg;
		logic aluSrcImm;
		logic branch;
		logic jump;
		logic jumpReg;
		logic link;
		logic invA;
		logic invB;
		logic cIn;
		logic dump;
		logic illegal;
		// on branches bit 0 picks the not-equal sense
		aluOp_t aluOp;
	} ctrl_t;

	// write port coming back from writeback
	typedef struct packed {
		logic en;
		isaPkg::regIdx_t sel;
		isaPkg::word_t data;
	} wbBus_t;

	// pipeline record between decode and execute
	typedef struct packed {
		ctrl_t ctrl;
		isaPkg::word_t a;
		isaPkg::word_t b;
		isaPkg::word_t imm;
		isaPkg::regIdx_t dst;
	} idEx_t;

endpackage

// File: hdl/isaPkg.sv
package isaPkg;

	// one machine word, also the instruction width
	typedef logic [15:0] word_t;
	// index into the eight-entry register file
	typedef logic [2:0] regIdx_t;
	// alu function field of R-format instructions
	typedef logic [1:0] funct_t;

	// major opcodes, any code not listed traps as illegal
	typedef enum logic [4:0] {
		HALT  = 5'b00000,
		NOP   = 5'b00001,
		J     = 5'b00100,
		JR    = 5'b00101,
		JAL   = 5'b00110,
		JALR  = 5'b00111,
		ADDI  = 5'b01000,
		SUBI  = 5'b01001,
		XORI  = 5'b01010,
		ANDNI = 5'b01011,
		BEQZ  = 5'b01100,
		BNEZ  = 5'b01101,
		ST    = 5'b10000,
		LD    = 5'b10001,
		SLBI  = 5'b10010,
		STU   = 5'b10011,
		LBI   = 5'b11000,
		ALUR  = 5'b11011
	} opcode_t;

	// funct codes of the R-format group
	localparam funct_t fnAdd  = 2'b00;
	localparam funct_t fnSub  = 2'b01;
	localparam funct_t fnXor  = 2'b10;
	localparam funct_t fnAndn = 2'b11;

	// how the low instruction bits become the immediate
	typedef enum logic [2:0] {
		none,
		sext5,
		zext5,
		sext8,
		zext8,
		sext11
	} immKind_t;

	// field positions inside the instruction word
	localparam int opMsb = 15;
	localparam int opLsb = 11;
	localparam int rsMsb = 10;
	localparam int rsLsb = 8;
	localparam int rtMsb = 7;
	localparam int rtLsb = 5;
	// R-format destination
	localparam int rdRMsb = 4;
	localparam int rdRLsb = 2;
	// I-format destination, shares bits with rt
	localparam int rdIMsb = 7;
	localparam int rdILsb = 5;
	localparam int functMsb = 1;
	localparam int functLsb = 0;
	// widest immediate field, J-format displacement
	localparam int immFieldW = 11;

	// JAL and JALR write the return address here
	localparam regIdx_t linkReg = 3'd7;

endpackage
